// File: source/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;     // data and address word
    typedef logic [4:0]  reg_addr_t; // regfile index

    // opcode field, bits 31:27
    typedef enum logic [4:0] {
        OP_RTYPE = 5'b00000,
        OP_J     = 5'b00001,
        OP_BNE   = 5'b00010,
        OP_JAL   = 5'b00011,
        OP_JR    = 5'b00100,
        OP_ADDI  = 5'b00101,
        OP_BLT   = 5'b00110,
        OP_SW    = 5'b00111,
        OP_LW    = 5'b01000
    } opcode_e;

    // alu op field of r-type, bits 6:2
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        logic [4:0] shamt;
        alu_op_e   alu_op;
        logic [1:0] spare; // unused
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rd;
        reg_addr_t   rs;
        logic [16:0] imm; // signed
    } i_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [26:0] target; // absolute word address
    } j_fmt_t;

    // opcode sits in the same bits for every view
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_t;

    localparam reg_addr_t LINK_REG = 5'd31; // jal return address

    function automatic word_t sign_extend_imm(logic [16:0] imm);
        return {{15{imm[16]}}, imm};
    endfunction

endpackage

// File: source/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // pc override request from a later stage
    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // fetch -> decode
    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } fd_t;

    // decode -> execute
    typedef struct packed {
        word_t  pc;
        instr_t instr;
        word_t  op_a; // regfile port a value
        word_t  op_b; // regfile port b value
    } dx_t;

    // execute -> memory
    typedef struct packed {
        word_t  pc;
        instr_t instr;
        word_t  result;     // alu out, also dmem address
        word_t  store_data; // sw payload
    } xm_t;

    // memory -> writeback
    typedef struct packed {
        word_t  pc;
        instr_t instr;
        word_t  result;
        word_t  load_data; // lw payload
    } mw_t;

endpackage

// File: source/alu.sv
module alu import isa_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    input  logic [4:0] shamt,
    output word_t      result,
    output logic       is_not_equal,
    output logic       is_less_than
);

    word_t diff;
    logic  sub_ovf;

    assign diff    = a - b;
    assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]); // signed overflow of a - b

    // flags from the subtraction
    assign is_not_equal = |diff;
    assign is_less_than = diff[31] ^ sub_ovf; // correct sign even on overflow

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLL: result = a << shamt;
            ALU_SRA: result = $signed(a) >>> shamt; // arithmetic, keeps sign
            default: result = '0; // unsupported op
        endcase
    end

endmodule

// File: source/fetch_stage.sv
module fetch_stage import isa_pkg::*; import pipe_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic      clock,
    input  logic      rst,
    input  word_t     q_imem,
    input  redirect_t jr_redirect,
    input  redirect_t br_redirect,
    output word_t     address_imem,
    output fd_t       fd
);

    word_t  pc;
    word_t  pc_next;
    instr_t fetched;
    logic   is_direct_jump;

    assign fetched        = q_imem;
    assign is_direct_jump = fetched.j.opcode inside {OP_J, OP_JAL}; // no delay slot for these
    assign address_imem   = pc;

    // next pc, earliest decision wins
    always_comb begin
        if (is_direct_jump)
            pc_next = {5'b0, fetched.j.target};
        else if (jr_redirect.taken)
            pc_next = jr_redirect.target; // from decode
        else if (br_redirect.taken)
            pc_next = br_redirect.target; // from execute
        else
            pc_next = pc + 32'd1;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= RESET_PC;
            fd <= '0; // add r0, r0, r0
        end else begin
            pc       <= pc_next;
            fd.pc    <= pc;
            fd.instr <= fetched;
        end
    end

endmodule

// File: source/decode_stage.sv
module decode_stage import isa_pkg::*; import pipe_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  fd_t       fd,
    input  word_t     data_read_reg_a,
    input  word_t     data_read_reg_b,
    output reg_addr_t ctrl_read_reg_a,
    output reg_addr_t ctrl_read_reg_b,
    output redirect_t jr_redirect,
    output dx_t       dx
);

    logic is_jr;
    logic rd_on_port_b;

    assign is_jr        = fd.instr.r.opcode == OP_JR;
    // sw data and branch compare both need rd
    assign rd_on_port_b = fd.instr.r.opcode inside {OP_SW, OP_BNE, OP_BLT};

    assign ctrl_read_reg_a = is_jr ? fd.instr.r.rd : fd.instr.r.rs;
    assign ctrl_read_reg_b = rd_on_port_b ? fd.instr.r.rd : fd.instr.r.rt;

    // jr target straight off port a, one slot executes behind it
    assign jr_redirect.taken  = is_jr;
    assign jr_redirect.target = data_read_reg_a;

    always_ff @(posedge clock) begin
        if (rst) begin
            dx <= '0;
        end else begin
            dx.pc    <= fd.pc;
            dx.instr <= fd.instr;
            dx.op_a  <= data_read_reg_a;
            dx.op_b  <= data_read_reg_b;
        end
    end

endmodule

// File: source/execute_stage.sv
module execute_stage import isa_pkg::*; import pipe_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  dx_t       dx,
    output redirect_t br_redirect,
    output xm_t       xm
);

    logic    use_imm;
    logic    is_bne;
    logic    is_blt;
    logic    cmp_ne;
    logic    cmp_lt;
    word_t   imm;
    word_t   alu_b;
    word_t   alu_result;
    alu_op_e alu_op;

    assign imm     = sign_extend_imm(dx.instr.i.imm);
    assign use_imm = dx.instr.r.opcode inside {OP_ADDI, OP_LW, OP_SW};
    assign is_bne  = dx.instr.r.opcode == OP_BNE;
    assign is_blt  = dx.instr.r.opcode == OP_BLT;

    // i-type always adds, r-type takes its own op
    assign alu_b  = use_imm ? imm : dx.op_b;
    assign alu_op = use_imm ? ALU_ADD : dx.instr.r.alu_op;

    alu u_main_alu (
        .a            (dx.op_a),
        .b            (alu_b),
        .op           (alu_op),
        .shamt        (dx.instr.r.shamt),
        .result       (alu_result),
        .is_not_equal (),
        .is_less_than ()
    );

    // rd - rs, so lt means rd < rs
    alu u_branch_cmp (
        .a            (dx.op_b),
        .b            (dx.op_a),
        .op           (ALU_SUB),
        .shamt        (5'd0),
        .result       (),
        .is_not_equal (cmp_ne),
        .is_less_than (cmp_lt)
    );

    assign br_redirect.taken  = (is_bne && cmp_ne) || (is_blt && cmp_lt);
    assign br_redirect.target = dx.pc + 32'd1 + imm; // relative to pc+1

    always_ff @(posedge clock) begin
        if (rst) begin
            xm <= '0;
        end else begin
            xm.pc         <= dx.pc;
            xm.instr      <= dx.instr;
            xm.result     <= alu_result;
            xm.store_data <= dx.op_b; // rd value for sw
        end
    end

endmodule

// File: source/memory_stage.sv
module memory_stage import isa_pkg::*; import pipe_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  xm_t   xm,
    input  word_t q_dmem,
    output word_t address_dmem,
    output word_t data,
    output logic  wren,
    output mw_t   mw
);

    assign address_dmem = xm.result;     // rs + imm for lw/sw
    assign data         = xm.store_data;
    assign wren         = xm.instr.r.opcode == OP_SW;

    always_ff @(posedge clock) begin
        if (rst) begin
            mw <= '0;
        end else begin
            mw.pc        <= xm.pc;
            mw.instr     <= xm.instr;
            mw.result    <= xm.result;
            mw.load_data <= q_dmem; // dmem read is combinational
        end
    end

endmodule

// File: source/writeback_stage.sv
module writeback_stage import isa_pkg::*; import pipe_pkg::*; (
    input  mw_t       mw,
    output logic      ctrl_write_enable,
    output reg_addr_t ctrl_write_reg,
    output word_t     data_write_reg
);

    logic is_jal;
    logic is_lw;

    assign is_jal = mw.instr.r.opcode == OP_JAL;
    assign is_lw  = mw.instr.r.opcode == OP_LW;

    // return address for jal, else load data or alu result
    assign data_write_reg = is_jal ? mw.pc + 32'd1 :
                            is_lw  ? mw.load_data  :
                                     mw.result;

    assign ctrl_write_reg = is_jal ? LINK_REG : mw.instr.r.rd;

    // nothing to write back for these
    assign ctrl_write_enable = !(mw.instr.r.opcode inside {OP_SW, OP_JR, OP_BNE, OP_BLT});

endmodule

// File: source/processor.sv
module processor import isa_pkg::*; import pipe_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic      clock,
    input  logic      rst,
    output word_t     address_imem,
    input  word_t     q_imem,
    output word_t     address_dmem,
    output word_t     data,
    output logic      wren,
    input  word_t     q_dmem,
    output logic      ctrl_write_enable,
    output reg_addr_t ctrl_write_reg,
    output word_t     data_write_reg,
    output reg_addr_t ctrl_read_reg_a,
    output reg_addr_t ctrl_read_reg_b,
    input  word_t     data_read_reg_a,
    input  word_t     data_read_reg_b
);

    fd_t       fd;
    dx_t       dx;
    xm_t       xm;
    mw_t       mw;
    redirect_t jr_redirect; // decode -> fetch
    redirect_t br_redirect; // execute -> fetch

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clock, .rst, .q_imem, .jr_redirect, .br_redirect, .address_imem, .fd
    );

    decode_stage u_decode (
        .clock, .rst, .fd, .data_read_reg_a, .data_read_reg_b,
        .ctrl_read_reg_a, .ctrl_read_reg_b, .jr_redirect, .dx
    );

    execute_stage u_execute (.clock, .rst, .dx, .br_redirect, .xm);

    memory_stage u_memory (.clock, .rst, .xm, .q_dmem, .address_dmem, .data, .wren, .mw);

    writeback_stage u_writeback (.mw, .ctrl_write_enable, .ctrl_write_reg, .data_write_reg);

endmodule

// File: dv/processor_props.sv
module processor_props import isa_pkg::*; (
    input logic  clock,
    input logic  rst,
    input word_t address_imem,
    input word_t q_imem,
    input logic  wren,
    input logic  jr_taken, // decode redirect
    input logic  br_taken  // execute redirect
);

    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0; // read by the testbench at the end
    logic is_jump;

    assign is_jump = q_imem[31:27] inside {OP_J, OP_JAL};

    // pc parked at zero and no store through reset and one cycle past it
    assert property (@(posedge clock) rst |=> (address_imem == '0 && !wren))
        else begin fail_count++; $error("pc or wren not cleared by reset"); end

    // plain fetch steps by one word
    assert property (@(posedge clock) disable iff (rst)
        (!is_jump && !jr_taken && !br_taken) |=> address_imem == $past(address_imem) + 32'd1)
        else begin fail_count++; $error("fetch did not step to the next word"); end

    // j and jal steer fetch in the same cycle
    assert property (@(posedge clock) disable iff (rst)
        is_jump |=> address_imem == {5'b0, $past(q_imem[26:0])})
        else begin fail_count++; $error("fetch did not follow the jump target"); end

    // store strobe three cycles after sw left imem, only once the pipe has refilled
    assert property (@(posedge clock) disable iff (rst)
        (!$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3))
            |-> wren == ($past(q_imem[31:27], 3) == OP_SW))
        else begin fail_count++; $error("wren does not line up with a fetched sw"); end

endmodule

bind processor processor_props u_props (
    .clock        (clock),
    .rst          (rst),
    .address_imem (address_imem),
    .q_imem       (q_imem),
    .wren         (wren),
    .jr_taken     (jr_redirect.taken),
    .br_taken     (br_redirect.taken)
);

// File: dv/processor_tb.sv
module processor_tb import isa_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    RESET_CYCLES = 10;
    localparam int    PROG_WORDS   = 48;
    localparam int    DRAIN_CYCLES = 20;
    localparam int    MAX_CYCLES   = (RESET_CYCLES + PROG_WORDS + DRAIN_CYCLES) * 2;
    localparam int    PIPE_DEPTH   = 8;      // fetch to writeback plus margin
    localparam word_t END_ADDR     = 32'd45; // j to itself parks fetch
    localparam int    STORE_ADDR   = 10;     // r3 + 2

    logic      clock;
    logic      rst;
    word_t     address_imem, q_imem, address_dmem, data, q_dmem;
    logic      wren, ctrl_write_enable;
    reg_addr_t ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;
    word_t     data_write_reg, data_read_reg_a, data_read_reg_b;

    word_t       imem [64];
    word_t       dmem [64];
    word_t       regs [32];
    word_t       exp_reg [32]; // expected regfile after the run
    logic [15:0] lfsr_state = 16'd51897;
    int          errors = 0;
    int          cycles = 0;

    processor #(.RESET_PC(32'd0)) u_processor (.*);

    // memories and regfile read combinationally
    assign q_imem = imem[address_imem[5:0]];
    assign q_dmem = dmem[address_dmem[5:0]];
    // write-before-read on a same-cycle hit
    assign data_read_reg_a = (ctrl_read_reg_a == 5'd0) ? '0 :
        (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a) ? data_write_reg
        : regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_read_reg_b == 5'd0) ? '0 :
        (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b) ? data_write_reg
        : regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (wren) dmem[address_dmem[5:0]] <= data;
        if (ctrl_write_enable && ctrl_write_reg != 5'd0)
            regs[ctrl_write_reg] <= data_write_reg; // r0 stays zero
    end

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [16:0] rand_imm();
        logic [16:0] v;
        v = '0;
        for (int i = 0; i < 17; i++) v = {v[15:0], lfsr_bit()}; // one step per bit
        return v;
    endfunction

    function automatic word_t fill_word(int addr);
        return word_t'(addr) * 32'h9e37_79b9 + 32'h0bad_0000; // spreads every address bit
    endfunction

    function automatic word_t rtype(reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
                                    logic [4:0] shamt, alu_op_e op);
        return {OP_RTYPE, rd, rs, rt, shamt, op, 2'b00};
    endfunction

    function automatic word_t itype(opcode_e opc, reg_addr_t rd, reg_addr_t rs,
                                    logic [16:0] imm);
        return {opc, rd, rs, imm};
    endfunction

    function automatic word_t jtype(opcode_e opc, word_t target);
        return {opc, target[26:0]};
    endfunction

    task automatic load_program();
        logic [16:0] imm1, imm2, imm3;
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < 46) ? 32'd0 : jtype(OP_J, i); // nops then self loops
            dmem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            regs[i]    = '0;
            exp_reg[i] = '0;
        end
        imm1 = rand_imm();
        imm2 = rand_imm() | 17'h1_0000; // sign bit set so sra and blt see a negative r2
        imm3 = rand_imm();
        imem[0]  = itype(OP_ADDI, 5'd1, 5'd0, imm1);
        imem[1]  = itype(OP_ADDI, 5'd2, 5'd0, imm2);
        imem[2]  = itype(OP_ADDI, 5'd3, 5'd0, 17'd8); // dmem base
        imem[3]  = itype(OP_ADDI, 5'd19, 5'd0, imm3);
        imem[8]  = rtype(5'd4, 5'd1, 5'd2, 5'd0, ALU_ADD);
        imem[9]  = rtype(5'd5, 5'd1, 5'd2, 5'd0, ALU_SUB);
        imem[10] = rtype(5'd6, 5'd1, 5'd2, 5'd0, ALU_AND);
        imem[11] = rtype(5'd7, 5'd1, 5'd2, 5'd0, ALU_OR);
        imem[12] = rtype(5'd8, 5'd1, 5'd0, 5'd3, ALU_SLL);
        imem[13] = rtype(5'd9, 5'd2, 5'd0, 5'd4, ALU_SRA);
        imem[14] = itype(OP_SW, 5'd4, 5'd3, 17'd2);
        imem[19] = itype(OP_LW, 5'd10, 5'd3, 17'd2);
        imem[20] = jtype(OP_JAL, 32'd26);
        imem[21] = itype(OP_ADDI, 5'd14, 5'd0, 17'h14); // return point
        imem[22] = jtype(OP_J, 32'd33);
        imem[26] = itype(OP_ADDI, 5'd11, 5'd0, 17'h11);
        imem[30] = itype(OP_JR, 5'd31, 5'd0, 17'd0);
        imem[31] = itype(OP_ADDI, 5'd12, 5'd0, 17'h12); // jr slot still runs
        imem[32] = itype(OP_ADDI, 5'd13, 5'd0, 17'h13); // never fetched
        imem[33] = itype(OP_BNE, 5'd3, 5'd0, 17'd3);    // 8 != 0 branches to 37
        imem[34] = itype(OP_ADDI, 5'd15, 5'd0, 17'h15);
        imem[36] = itype(OP_ADDI, 5'd16, 5'd0, 17'h16); // skipped marker
        imem[37] = itype(OP_BLT, 5'd2, 5'd0, 17'd3);    // negative r2 < 0 branches to 41
        imem[40] = itype(OP_ADDI, 5'd17, 5'd0, 17'h17); // skipped marker
        imem[41] = itype(OP_BLT, 5'd3, 5'd2, 17'd3);    // 8 < negative r2 fails
        imem[44] = itype(OP_ADDI, 5'd18, 5'd0, 17'h18); // runs
        imem[45] = jtype(OP_J, END_ADDR);
        // expected state from the isa rules
        exp_reg[1]  = $signed(imm1);
        exp_reg[2]  = $signed(imm2);
        exp_reg[3]  = 32'd8;
        exp_reg[19] = $signed(imm3);
        exp_reg[4]  = exp_reg[1] + exp_reg[2];
        exp_reg[5]  = exp_reg[1] - exp_reg[2];
        exp_reg[6]  = exp_reg[1] & exp_reg[2];
        exp_reg[7]  = exp_reg[1] | exp_reg[2];
        exp_reg[8]  = exp_reg[1] << 3;
        exp_reg[9]  = $signed(exp_reg[2]) >>> 4;
        exp_reg[10] = exp_reg[4]; // loaded back from STORE_ADDR
        exp_reg[31] = 32'd21;     // jal address + 1
        exp_reg[11] = 32'h11;
        exp_reg[12] = 32'h12;
        exp_reg[14] = 32'h14;
        exp_reg[15] = 32'h15;
        exp_reg[18] = 32'h18;
    endtask

    task automatic check_word(string name, word_t got, word_t expected);
        assert (got === expected) else begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: fetch never reached the end loop within %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        load_program();
        repeat (RESET_CYCLES) @(posedge clock);
        #2 rst = 1'b0;
        do @(negedge clock); while (address_imem !== END_ADDR);
        repeat (PIPE_DEPTH) @(negedge clock); // let the last writes retire
        for (int i = 0; i < 32; i++) check_word($sformatf("r%0d", i), regs[i], exp_reg[i]);
        for (int i = 0; i < 64; i++)
            check_word($sformatf("dmem[%0d]", i), dmem[i],
                       (i == STORE_ADDR) ? exp_reg[4] : fill_word(i));
        $display("end of run: %0d mismatches, %0d assertion failures",
                 errors, u_processor.u_props.fail_count);
        if (errors == 0 && u_processor.u_props.fail_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: processor.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/alu.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/writeback_stage.sv
source/processor.sv
dv/processor_props.sv
dv/processor_tb.sv

// File: Bender.yml
package:
  name: processor

sources:
  - source/isa_pkg.sv
  - source/pipe_pkg.sv
  - source/alu.sv
  - source/fetch_stage.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/memory_stage.sv
  - source/writeback_stage.sv
  - source/processor.sv
  - target: test
    files:
      - dv/processor_props.sv
      - dv/processor_tb.sv
